/* pclTop.f */
+incdir+common
common/pclTypesPkg.sv
common/ccuPkg.sv
common/wbIf.sv
design/startDebounce.sv
ctrl/ccuFsm.sv
glb/glbBank.sv
design/padItf.sv
pool/poolCore.sv
design/pclTop.sv
bench/pclTop_assert.sv
bench/pclTop_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the pclTop testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pclTop_tb -f pclTop.f -o pclTop_sim
./obj_dir/pclTop_sim

/* bench/pclTop_tb.sv */
`include "pcl_defs.svh"

module pclTop_tb import pclTypesPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumRuns  = 2;
    localparam int MaxWords = 12;
    localparam int MaxRes   = MaxWords / `POOL_K;
    localparam int Timeout  = 200;

    logic clk;
    logic arstN;
    logic startBtn;
    datT  inDat;
    logic inVld;
    logic inLast;
    logic outRdy;
    logic inRdy;
    datT  outDat;
    logic outVld;
    logic outLast;
    logic netFnh;

    int    seed;
    int    r;
    string runName  [NumRuns];
    int    runLen   [NumRuns];
    datT   runWords [NumRuns][MaxWords];
    datT   runMax   [NumRuns][MaxRes];

    pclTop UUT (
        .clk      (clk),
        .arstN    (arstN),
        .startBtn (startBtn),
        .inDat    (inDat),
        .inVld    (inVld),
        .inLast   (inLast),
        .outRdy   (outRdy),
        .inRdy    (inRdy),
        .outDat   (outDat),
        .outVld   (outVld),
        .outLast  (outLast),
        .netFnh   (netFnh)
    );

    always #20 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic announceFail();
        $display("*** FAILED ***");
    endtask

    task automatic matchWord(input string name, input datT exp, input datT act);
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            announceFail();
            $fatal(1, "Wrong data word");
        end
    endtask

    task automatic expectFlag(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            announceFail();
            $fatal(1, "Wrong control flag");
        end
    endtask

    // Runs with inputs and the maxima worked out by hand
    task automatic fillTable();
        runName[0]  = "eight words";
        runLen[0]   = 8;
        runWords[0] = '{16'h0003, 16'h0010, 16'h0007, 16'h000F,
                        16'h8000, 16'h7FFF, 16'h8001, 16'h0001,
                        16'h0000, 16'h0000, 16'h0000, 16'h0000};
        runMax[0]   = '{16'h0010, 16'h8001, 16'h0000};
        runName[1]  = "twelve words";
        runLen[1]   = 12;
        runWords[1] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000,
                        16'h1234, 16'hFFFF, 16'h0042, 16'hFFFE,
                        16'h0100, 16'h00FF, 16'h0101, 16'h0000};
        runMax[1]   = '{16'h0000, 16'hFFFF, 16'h0101};
    endtask

    task automatic pressButton(input int cycles);
        startBtn = 1'b1;
        repeat (cycles) nextCycle();
        startBtn = 1'b0;
    endtask

    task automatic loadWords(input int idx);
        int   i;
        int   waitCnt;
        logic seenRdy;
        seenRdy = 1'b0;
        for (i = 0; i < runLen[idx]; i++) begin
            inDat   = runWords[idx][i];
            inLast  = (i == runLen[idx] - 1);
            inVld   = 1'b1;
            waitCnt = 0;
            while (!inRdy) begin
                waitCnt++;
                if (waitCnt > Timeout) begin
                    announceFail();
                    $fatal(1, "Timeout: the DUT never became ready for input words");
                end
                nextCycle();
            end
            // First ready cycle is the start of LOAD
            if (!seenRdy) begin
                expectFlag($sformatf("%s netFnh at load", runName[idx]), 1'b0, netFnh);
                seenRdy = 1'b1;
            end
            nextCycle();
        end
        inVld  = 1'b0;
        inLast = 1'b0;
    endtask

    task automatic collectMaxima(input int idx);
        int    got;
        int    waitCnt;
        int    rnd;
        int    numRes;
        logic  holdPend;
        datT   heldDat;
        logic  heldLast;
        string tag;
        got      = 0;
        waitCnt  = 0;
        holdPend = 1'b0;
        heldDat  = '0;
        heldLast = 1'b0;
        numRes   = runLen[idx] / `POOL_K;
        while (got < numRes) begin
            tag = $sformatf("%s result %0d", runName[idx], got);
            // Stalled word must stay put
            if (holdPend) begin
                expectFlag({tag, " outVld held"}, 1'b1, outVld);
                matchWord({tag, " outDat held"}, heldDat, outDat);
                expectFlag({tag, " outLast held"}, heldLast, outLast);
            end
            expectFlag({tag, " netFnh in dump"}, 1'b0, netFnh);
            rnd      = $random(seed);
            outRdy   = rnd[0];
            holdPend = outVld && !outRdy;
            heldDat  = outDat;
            heldLast = outLast;
            if (outVld && outRdy) begin
                matchWord(tag, runMax[idx][got], outDat);
                expectFlag({tag, " outLast"}, got == numRes - 1, outLast);
                got++;
                waitCnt = 0;
            end
            waitCnt++;
            if (waitCnt > Timeout) begin
                announceFail();
                $fatal(1, "Timeout: the DUT stopped sending result words");
            end
            nextCycle();
        end
        outRdy = 1'b0;
    endtask

    task automatic waitFinish(input int idx);
        int waitCnt;
        waitCnt = 0;
        while (!netFnh) begin
            expectFlag($sformatf("%s no extra output", runName[idx]), 1'b0, outVld);
            waitCnt++;
            if (waitCnt > Timeout) begin
                announceFail();
                $fatal(1, "Timeout: the finished flag never rose after the dump");
            end
            nextCycle();
        end
        expectFlag($sformatf("%s outVld after finish", runName[idx]), 1'b0, outVld);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        seed     = 27953;
        clk      = 1'b0;
        arstN    = 1'b0;
        startBtn = 1'b0;
        inDat    = '0;
        inVld    = 1'b0;
        inLast   = 1'b0;
        outRdy   = 1'b0;
        fillTable();

        repeat (3) @(posedge clk);
        #2;
        arstN = 1'b1;

        expectFlag("reset inRdy", 1'b0, inRdy);
        expectFlag("reset outVld", 1'b0, outVld);
        expectFlag("reset netFnh", 1'b0, netFnh);

        // Too short for the debounce filter
        pressButton(`DEB_TICKS / 2);
        repeat (30) begin
            nextCycle();
            expectFlag("short press inRdy", 1'b0, inRdy);
        end

        for (r = 0; r < NumRuns; r++) begin
            pressButton(`DEB_TICKS + 4);
            loadWords(r);
            collectMaxima(r);
            waitFinish(r);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* bench/pclTop_assert.sv */
module pclTop_assert (
    input logic clk,
    input logic arstN,
    input logic padCyc,
    input logic padStb,
    input logic padAck,
    input logic poolCyc,
    input logic poolStb,
    input logic poolAck
);

    timeunit 1ns;
    timeprecision 100ps;

    // ======================================================================
    // Wishbone classic slave rules on both buffer ports
    // ======================================================================
    padAckNeedsStb: assert property (@(posedge clk) disable iff (!arstN)
        padAck |-> padStb)
        else $error("pad ack without strobe");

    poolAckNeedsStb: assert property (@(posedge clk) disable iff (!arstN)
        poolAck |-> poolStb)
        else $error("pool ack without strobe");

    // One ack per request, even with back-to-back strobes
    padAckSingle: assert property (@(posedge clk) disable iff (!arstN)
        (padAck && padStb) |=> !padAck)
        else $error("pad ack held for two cycles");

    poolAckSingle: assert property (@(posedge clk) disable iff (!arstN)
        (poolAck && poolStb) |=> !poolAck)
        else $error("pool ack held for two cycles");

    // Phases never overlap on the buffer
    cycExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(padCyc && poolCyc))
        else $error("pad and pool cycles open together");

endmodule

bind glbBank pclTop_assert uBufAssert (
    .clk     (clk),
    .arstN   (arstN),
    .padCyc  (wbPad.cyc),
    .padStb  (wbPad.stb),
    .padAck  (wbPad.ack),
    .poolCyc (wbPool.cyc),
    .poolStb (wbPool.stb),
    .poolAck (wbPool.ack)
);

/* design/pclTop.sv */
module pclTop import pclTypesPkg::*; import ccuPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic startBtn,
    input  datT  inDat,
    input  logic inVld,
    input  logic inLast,
    input  logic outRdy,
    output logic inRdy,
    output datT  outDat,
    output logic outVld,
    output logic outLast,
    output logic netFnh
);

    logic     startPulse;
    logic     loadDone;
    logic     poolDone;
    logic     dumpDone;
    ccuPhaseT phase;
    adrT      loadCnt;

    // Buffer buses, pad side and pool side
    wbIf wbPad ();
    wbIf wbPool ();

    // ======================================================================
    // Control
    // ======================================================================
    startDebounce uStartDebounce (
        .clk        (clk),
        .arstN      (arstN),
        .btn        (startBtn),
        .startPulse (startPulse)
    );

    ccuFsm uCcuFsm (
        .clk        (clk),
        .arstN      (arstN),
        .startPulse (startPulse),
        .loadDone   (loadDone),
        .poolDone   (poolDone),
        .dumpDone   (dumpDone),
        .phase      (phase),
        .netFnh     (netFnh)
    );

    // ======================================================================
    // Buffer, pads and pooling
    // ======================================================================
    glbBank uGlbBank (
        .clk    (clk),
        .arstN  (arstN),
        .wbPad  (wbPad.slave),
        .wbPool (wbPool.slave)
    );

    padItf uPadItf (
        .clk      (clk),
        .arstN    (arstN),
        .phase    (phase),
        .inDat    (inDat),
        .inVld    (inVld),
        .inLast   (inLast),
        .outRdy   (outRdy),
        .inRdy    (inRdy),
        .outDat   (outDat),
        .outVld   (outVld),
        .outLast  (outLast),
        .loadDone (loadDone),
        .dumpDone (dumpDone),
        .loadCnt  (loadCnt),
        .wb       (wbPad.master)
    );

    poolCore uPoolCore (
        .clk      (clk),
        .arstN    (arstN),
        .phase    (phase),
        .loadCnt  (loadCnt),
        .poolDone (poolDone),
        .wb       (wbPool.master)
    );

endmodule

/* pool/poolCore.sv */
`include "pcl_defs.svh"

module poolCore import pclTypesPkg::*; import ccuPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  ccuPhaseT phase,
    input  adrT      loadCnt,
    output logic     poolDone,
    wbIf.master      wb
);

    localparam int GrpW = $clog2(`POOL_K);

    typedef enum logic [1:0] {
        PS_IDLE,
        PS_READ,
        PS_WRITE,
        PS_DONE
    } poolStT;

    poolStT          state;
    adrT             rdAdr;
    adrT             grpIdx;
    logic [GrpW-1:0] inGrp;
    datT             runMax;
    datT             curMax;
    logic            grpEnd;
    logic            lastWord;

    assign grpEnd   = (inGrp == GrpW'(`POOL_K - 1));
    assign lastWord = (rdAdr == loadCnt - adrT'(1));
    // Unsigned compare, first word of a group restarts the maximum
    assign curMax   = (inGrp == '0 || wb.datR > runMax) ? wb.datR : runMax;

    // ======================================================================
    // Read groups, write one maximum per group
    // ======================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= PS_IDLE;
            wb.cyc   <= 1'b0;
            wb.stb   <= 1'b0;
            wb.we    <= 1'b0;
            rdAdr    <= '0;
            grpIdx   <= '0;
            inGrp    <= '0;
            poolDone <= 1'b0;
        end else begin
            poolDone <= 1'b0;
            case (state)
                PS_IDLE: begin
                    if (phase == PH_POOL) begin
                        state  <= PS_READ;
                        wb.cyc <= 1'b1;
                        wb.stb <= 1'b1;
                        wb.we  <= 1'b0;
                        rdAdr  <= '0;
                        grpIdx <= '0;
                        inGrp  <= '0;
                    end
                end
                PS_READ: begin
                    if (wb.ack) begin
                        if (grpEnd) begin
                            state <= PS_WRITE;
                            wb.we <= 1'b1;
                            inGrp <= '0;
                        end else begin
                            inGrp <= inGrp + GrpW'(1);
                            rdAdr <= rdAdr + adrT'(1);
                        end
                    end
                end
                PS_WRITE: begin
                    if (wb.ack) begin
                        grpIdx <= grpIdx + adrT'(1);
                        if (lastWord) begin
                            state    <= PS_DONE;
                            wb.cyc   <= 1'b0;
                            wb.stb   <= 1'b0;
                            wb.we    <= 1'b0;
                            poolDone <= 1'b1;
                        end else begin
                            state <= PS_READ;
                            wb.we <= 1'b0;
                            rdAdr <= rdAdr + adrT'(1);
                        end
                    end
                end
                PS_DONE: begin
                    if (phase != PH_POOL) begin
                        state <= PS_IDLE;
                    end
                end
                default: state <= PS_IDLE;
            endcase
        end
    end

    // Address and running maximum
    always_ff @(posedge clk) begin
        if (state == PS_IDLE) begin
            wb.adr <= '0;
        end else if (state == PS_READ && wb.ack) begin
            runMax <= curMax;
            if (grpEnd) begin
                wb.adr  <= adrT'(`PCL_RES_BASE) + grpIdx;
                wb.datW <= curMax;
            end else begin
                wb.adr <= rdAdr + adrT'(1);
            end
        end else if (state == PS_WRITE && wb.ack) begin
            wb.adr <= rdAdr + adrT'(1);
        end
    end

endmodule

/* design/padItf.sv */
`include "pcl_defs.svh"

module padItf import pclTypesPkg::*; import ccuPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  ccuPhaseT phase,
    input  datT      inDat,
    input  logic     inVld,
    input  logic     inLast,
    input  logic     outRdy,
    output logic     inRdy,
    output datT      outDat,
    output logic     outVld,
    output logic     outLast,
    output logic     loadDone,
    output logic     dumpDone,
    output adrT      loadCnt,
    wbIf.master      wb
);

    logic loadFin;
    logic wrLast;
    adrT  rdIdx;
    adrT  resCnt;
    logic inAcc;
    logic outAcc;
    logic rdIssue;

    // One maximum per group in the result area
    assign resCnt = loadCnt / adrT'(`POOL_K);

    assign inRdy   = (phase == PH_LOAD) && !wb.cyc && !loadFin;
    assign inAcc   = inVld && inRdy;
    assign outAcc  = outVld && outRdy;
    // Next fetch only once the output register is free
    assign rdIssue = (phase == PH_DUMP) && !wb.cyc && !outVld && (rdIdx != resCnt);

    // ======================================================================
    // Bus requests and stream control
    // ======================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wb.cyc   <= 1'b0;
            wb.stb   <= 1'b0;
            wb.we    <= 1'b0;
            loadCnt  <= '0;
            loadFin  <= 1'b0;
            wrLast   <= 1'b0;
            rdIdx    <= '0;
            outVld   <= 1'b0;
            outLast  <= 1'b0;
            loadDone <= 1'b0;
            dumpDone <= 1'b0;
        end else begin
            loadDone <= 1'b0;
            dumpDone <= 1'b0;
            if (phase == PH_IDLE || phase == PH_DONE) begin
                loadCnt <= '0;
                loadFin <= 1'b0;
                rdIdx   <= '0;
            end
            if (inAcc) begin
                wb.cyc <= 1'b1;
                wb.stb <= 1'b1;
                wb.we  <= 1'b1;
                wrLast <= inLast;
            end else if (rdIssue) begin
                wb.cyc <= 1'b1;
                wb.stb <= 1'b1;
                wb.we  <= 1'b0;
            end else if (wb.ack) begin
                wb.cyc <= 1'b0;
                wb.stb <= 1'b0;
                if (wb.we) begin
                    loadCnt <= loadCnt + adrT'(1);
                    if (wrLast) begin
                        loadFin  <= 1'b1;
                        loadDone <= 1'b1;
                    end
                end else begin
                    rdIdx   <= rdIdx + adrT'(1);
                    outVld  <= 1'b1;
                    outLast <= (rdIdx == resCnt - adrT'(1));
                end
            end
            if (outAcc) begin
                outVld   <= 1'b0;
                outLast  <= 1'b0;
                dumpDone <= outLast;
            end
        end
    end

    // Address, write word and output word
    always_ff @(posedge clk) begin
        if (inAcc) begin
            wb.adr  <= loadCnt;
            wb.datW <= inDat;
        end else if (rdIssue) begin
            wb.adr <= adrT'(`PCL_RES_BASE) + rdIdx;
        end
        if (wb.ack && !wb.we) begin
            outDat <= wb.datR;
        end
    end

endmodule

/* glb/glbBank.sv */
`include "pcl_defs.svh"

module glbBank import pclTypesPkg::*; (
    input logic clk,
    input logic arstN,
    wbIf.slave  wbPad,
    wbIf.slave  wbPool
);

    datT  mem [0:`PCL_GLB_DEPTH-1];
    datT  rdDat;
    logic padFire;
    logic poolFire;
    logic fire;
    logic reqWe;
    adrT  reqAdr;
    datT  reqDat;

    // Pad port wins whenever its cycle is open
    assign padFire  = wbPad.cyc & wbPad.stb & ~wbPad.ack;
    assign poolFire = ~wbPad.cyc & wbPool.cyc & wbPool.stb & ~wbPool.ack;
    assign fire     = padFire | poolFire;

    assign reqWe  = wbPad.cyc ? wbPad.we   : wbPool.we;
    assign reqAdr = wbPad.cyc ? wbPad.adr  : wbPool.adr;
    assign reqDat = wbPad.cyc ? wbPad.datW : wbPool.datW;

    // Single-cycle ack, one edge after the strobe is seen
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbPad.ack  <= 1'b0;
            wbPool.ack <= 1'b0;
        end else begin
            wbPad.ack  <= padFire;
            wbPool.ack <= poolFire;
        end
    end

    // Memory array with registered read
    always_ff @(posedge clk) begin
        if (fire) begin
            if (reqWe) begin
                mem[reqAdr] <= reqDat;
            end else begin
                rdDat <= mem[reqAdr];
            end
        end
    end

    assign wbPad.datR  = rdDat;
    assign wbPool.datR = rdDat;

endmodule

/* ctrl/ccuFsm.sv */
module ccuFsm import ccuPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     startPulse,
    input  logic     loadDone,
    input  logic     poolDone,
    input  logic     dumpDone,
    output ccuPhaseT phase,
    output logic     netFnh
);

    ccuPhaseT phaseNxt;

    // ======================================================================
    // Next phase
    // ======================================================================
    always_comb begin
        phaseNxt = phase;
        case (phase)
            PH_IDLE: begin
                if (startPulse) begin
                    phaseNxt = PH_LOAD;
                end
            end
            PH_LOAD: begin
                if (loadDone) begin
                    phaseNxt = PH_POOL;
                end
            end
            PH_POOL: begin
                if (poolDone) begin
                    phaseNxt = PH_DUMP;
                end
            end
            PH_DUMP: begin
                if (dumpDone) begin
                    phaseNxt = PH_DONE;
                end
            end
            PH_DONE: begin
                // Restart from here, no return to idle
                if (startPulse) begin
                    phaseNxt = PH_LOAD;
                end
            end
            default: phaseNxt = PH_IDLE;
        endcase
    end

    // ======================================================================
    // Phase register and finish flag
    // ======================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase  <= PH_IDLE;
            netFnh <= 1'b0;
        end else begin
            phase  <= phaseNxt;
            netFnh <= (phaseNxt == PH_DONE);
        end
    end

endmodule

/* design/startDebounce.sv */
`include "pcl_defs.svh"

module startDebounce (
    input  logic clk,
    input  logic arstN,
    input  logic btn,
    output logic startPulse
);

    localparam int CntW = $clog2(`DEB_TICKS + 1);

    logic            btnMeta;
    logic            btnSync;
    logic            btnDeb;
    logic            btnDebD;
    logic [CntW-1:0] stableCnt;

    // Two-flop synchronizer for the raw button
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            btnMeta <= 1'b0;
            btnSync <= 1'b0;
        end else begin
            btnMeta <= btn;
            btnSync <= btnMeta;
        end
    end

    // New level adopted only after DEB_TICKS stable cycles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stableCnt <= '0;
            btnDeb    <= 1'b0;
        end else if (btnSync == btnDeb) begin
            stableCnt <= '0;
        end else if (stableCnt == CntW'(`DEB_TICKS - 1)) begin
            stableCnt <= '0;
            btnDeb    <= btnSync;
        end else begin
            stableCnt <= stableCnt + CntW'(1);
        end
    end

    // Release of the button starts a run
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            btnDebD    <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            btnDebD    <= btnDeb;
            startPulse <= btnDebD & ~btnDeb;
        end
    end

endmodule

/* common/wbIf.sv */
interface wbIf import pclTypesPkg::*; ();

    logic cyc;
    logic stb;
    logic we;
    adrT  adr;
    datT  datW;
    datT  datR;
    logic ack;

    // Request side
    modport master (
        output cyc, stb, we, adr, datW,
        input  datR, ack
    );

    // Buffer side
    modport slave (
        input  cyc, stb, we, adr, datW,
        output datR, ack
    );

endinterface

/* common/ccuPkg.sv */
package ccuPkg;

    // Phases of one accelerator run
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD,
        PH_POOL,
        PH_DUMP,
        PH_DONE
    } ccuPhaseT;

endpackage

/* common/pclTypesPkg.sv */
`include "pcl_defs.svh"

package pclTypesPkg;

    // One buffer or pad word
    typedef logic [`PCL_DAT_W-1:0] datT;

    // Buffer address, also used as a word count
    typedef logic [`PCL_ADR_W-1:0] adrT;

endpackage

/* common/pcl_defs.svh */
`ifndef PCL_DEFS_SVH
`define PCL_DEFS_SVH

// ======================================================================
// Datapath widths
// ======================================================================
`define PCL_DAT_W       16
`define PCL_ADR_W       6

// ======================================================================
// Global buffer layout
// ======================================================================
`define PCL_GLB_DEPTH   64
`define PCL_RES_BASE    32

// Pooling group size and button filter length
`define POOL_K          4
`define DEB_TICKS       8

`endif
